// ==== hdl/cache_control.sv ====
`default_nettype none

`include "cache_defs.svh"

module cache_control (
    input  logic                     clk,
    input  logic                     rst,
    input  cache_pkg::cpu_req_t      req,
    input  cache_pkg::lookup_t       lookup,
    input  logic                     dfp_resp,
    output cache_pkg::cache_state_t  state,
    output cache_pkg::mem_req_t      mem,
    output logic [`CACHE_WAYS-1:0]   data_we,
    output logic [`CACHE_WAYS-1:0]   tag_we,
    output logic [`CACHE_WAYS-1:0]   valid_we,
    output logic                     plru_we,
    output logic                     ufp_resp
);

    cache_pkg::cache_state_t state_next;
    logic                    req_write;
    logic                    req_valid;
    logic [`CACHE_WAYS-1:0]  hit_sel;
    logic [`CACHE_WAYS-1:0]  victim_sel;

    assign req_write  = (req.wmask != '0);
    assign req_valid  = req.read || req_write || req.pcs;
    assign hit_sel    = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << lookup.hit_way;
    assign victim_sel = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << lookup.victim_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::idle_s;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        mem        = '0;
        data_we    = '0;
        tag_we     = '0;
        valid_we   = '0;
        plru_we    = 1'b0;
        ufp_resp   = 1'b0;

        case (state)
            cache_pkg::idle_s: begin
                if (req_valid) begin
                    state_next = cache_pkg::compare_s;
                end
            end

            cache_pkg::compare_s: begin
                if (lookup.hit && req.pcs) begin
                    state_next = cache_pkg::pcs_write_s;
                end else if (lookup.hit) begin
                    // Read or write hit completes here
                    ufp_resp   = 1'b1;
                    plru_we    = 1'b1;
                    state_next = cache_pkg::idle_s;
                    if (req_write) begin
                        data_we = hit_sel;
                        tag_we  = hit_sel;
                    end
                end else if (lookup.victim_dirty) begin
                    state_next = cache_pkg::writeback_s;
                end else begin
                    state_next = cache_pkg::allocate_s;
                end
            end

            cache_pkg::writeback_s: begin
                mem.write = 1'b1;
                mem.addr  = {lookup.victim_tag, req.addr.f.index, {`CACHE_OFFSET_W{1'b0}}};
                if (dfp_resp) begin
                    state_next = cache_pkg::allocate_s;
                end
            end

            cache_pkg::allocate_s: begin
                mem.read = 1'b1;
                mem.addr = {req.addr.l.line, {`CACHE_OFFSET_W{1'b0}}};
                if (dfp_resp) begin
                    // Fill the victim way with a clean tag
                    data_we    = victim_sel;
                    tag_we     = victim_sel;
                    valid_we   = victim_sel;
                    state_next = cache_pkg::compare_s;
                end
            end

            cache_pkg::pcs_write_s: begin
                data_we    = hit_sel;
                tag_we     = hit_sel;
                plru_we    = 1'b1;
                ufp_resp   = 1'b1;
                state_next = cache_pkg::idle_s;
            end

            default: begin
                state_next = cache_pkg::idle_s;
            end
        endcase
    end

    // Only a dirty victim goes back to memory
    a_wb_dirty: assert property (@(posedge clk) disable iff (rst)
        mem.write |-> lookup.victim_dirty);

    // The PCS merge lands in a line that is still resident
    a_pcs_resident: assert property (@(posedge clk) disable iff (rst)
        (state == cache_pkg::pcs_write_s) |-> lookup.hit);

    // Memory strobe and address hold until the response arrives
    a_dfp_hold: assert property (@(posedge clk) disable iff (rst)
        ((mem.read || mem.write) && !dfp_resp) |=>
            ($stable(mem.read) && $stable(mem.write) && $stable(mem.addr)));

endmodule

`default_nettype wire

// ==== hdl/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry
`define CACHE_WAYS      4
`define CACHE_WAY_W     2
`define CACHE_SETS      16
`define CACHE_INDEX_W   4

// 32-byte lines
`define CACHE_OFFSET_W  5
`define CACHE_LINE_W    256

// One mask bit per line byte
`define CACHE_MASK_W    32

// Remaining upper address bits
`define CACHE_TAG_W     23

// CPU read word
`define CACHE_WORD_W    32

`endif

// ==== hdl/cache_line_merge.sv ====
`default_nettype none

`include "cache_defs.svh"

module cache_line_merge (
    input  cache_pkg::cache_state_t                  state,
    input  cache_pkg::cpu_req_t                      req,
    input  cache_pkg::lookup_t                       lookup,
    input  logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] lines,
    input  logic [`CACHE_LINE_W-1:0]                 dfp_rdata,
    input  logic [2:0]                               plru,
    output logic [`CACHE_LINE_W-1:0]                 wline,
    output logic [`CACHE_MASK_W-1:0]                 wmask,
    output logic [`CACHE_WORD_W-1:0]                 rdata,
    output logic [2:0]                               plru_next
);

    logic [`CACHE_WAY_W-1:0]  touched_way;
    logic [`CACHE_LINE_W-1:0] base_line;
    logic [`CACHE_LINE_W-1:0] new_line;

    // A fill replaces the whole line, so merge and word select use the hit way
    assign touched_way = lookup.hit_way;
    assign base_line   = lines[touched_way];

    always_comb begin
        case (state)
            cache_pkg::compare_s: begin
                wmask    = req.wmask;
                new_line = req.wdata;
            end
            cache_pkg::allocate_s: begin
                wmask    = '1;
                new_line = dfp_rdata;
            end
            cache_pkg::pcs_write_s: begin
                wmask    = req.pcs_mask;
                new_line = req.pcs_line;
            end
            default: begin
                wmask    = '0;
                new_line = req.wdata;
            end
        endcase
    end

    // Byte merge over the resident line
    always_comb begin
        for (int b = 0; b < `CACHE_MASK_W; b++) begin
            wline[b*8 +: 8] = wmask[b] ? new_line[b*8 +: 8] : base_line[b*8 +: 8];
        end
    end

    // Word select by offset bits [4:2]
    assign rdata = base_line[req.addr.f.offset[4:2]*`CACHE_WORD_W +: `CACHE_WORD_W];

    // Point the tree away from the way just used
    always_comb begin
        plru_next = plru;
        if (!touched_way[1]) begin
            plru_next[0] = 1'b1;
            plru_next[1] = ~touched_way[0];
        end else begin
            plru_next[0] = 1'b0;
            plru_next[2] = ~touched_way[0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        idle_s,
        compare_s,
        writeback_s,
        allocate_s,
        pcs_write_s
    } cache_state_t;

    // Tag, set and byte view of an address
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Line number view, used for the fill address
    typedef struct packed {
        logic [31-`CACHE_OFFSET_W:0] line;
        logic [`CACHE_OFFSET_W-1:0]  offset;
    } addr_line_t;

    typedef union packed {
        addr_fields_t f;
        addr_line_t   l;
    } cache_addr_u;

    typedef struct packed {
        cache_addr_u               addr;
        logic                      read;
        logic [`CACHE_MASK_W-1:0]  wmask;
        logic [`CACHE_LINE_W-1:0]  wdata;
        logic                      pcs;
        logic [`CACHE_MASK_W-1:0]  pcs_mask;
        logic [`CACHE_LINE_W-1:0]  pcs_line;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0]               addr;
        logic                      read;
        logic                      write;
        logic [`CACHE_LINE_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      hit;
        logic [`CACHE_WAY_W-1:0]   hit_way;
        logic [`CACHE_WAY_W-1:0]   victim_way;
        logic                      victim_dirty;
        logic [`CACHE_TAG_W-1:0]   victim_tag;
    } lookup_t;

    // Stored tag word, dirty bit on top
    typedef struct packed {
        logic                      dirty;
        logic [`CACHE_TAG_W-1:0]   tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== hdl/cache_tag_match.sv ====
`default_nettype none

`include "cache_defs.svh"

module cache_tag_match (
    input  cache_pkg::cache_addr_u                   addr,
    input  cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]  tags,
    input  logic [`CACHE_WAYS-1:0]                   valids,
    input  logic [2:0]                               plru,
    output cache_pkg::lookup_t                       lookup
);

    logic [`CACHE_WAYS-1:0]  hits;
    logic [`CACHE_WAY_W-1:0] hit_way;
    logic [`CACHE_WAY_W-1:0] free_way;
    logic                    free_found;
    logic [`CACHE_WAY_W-1:0] plru_way;
    logic [`CACHE_WAY_W-1:0] victim_way;

    always_comb begin
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            hits[i] = valids[i] && (tags[i].tag == addr.f.tag);
        end
    end

    // Encode the hit way
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (hits[i]) begin
                hit_way = `CACHE_WAY_W'(i);
            end
        end
    end

    // Lowest invalid way is filled first
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (!valids[i] && !free_found) begin
                free_found = 1'b1;
                free_way   = `CACHE_WAY_W'(i);
            end
        end
    end

    // Bit 0 picks the half, bits 1 and 2 the way inside it
    assign plru_way   = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};
    assign victim_way = free_found ? free_way : plru_way;

    always_comb begin
        lookup.hit          = |hits;
        lookup.hit_way      = hit_way;
        lookup.victim_way   = victim_way;
        lookup.victim_dirty = valids[victim_way] && tags[victim_way].dirty;
        lookup.victim_tag   = tags[victim_way].tag;
    end

    // A fill only happens on a miss, so a tag never lives in two ways
    always_comb begin
        if (!$isunknown(hits)) begin
            a_single_hit: assert final ($onehot0(hits));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_way_array.sv ====
`default_nettype none

`include "cache_defs.svh"

module cache_way_array #(
    parameter int WIDTH = 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      we,
    input  logic [`CACHE_INDEX_W-1:0] addr,
    input  logic [WIDTH-1:0]          din,
    output logic [WIDTH-1:0]          dout
);

    // One entry per set
    logic [WIDTH-1:0] mem [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= din;
        end
    end

    // Read is combinational, same-cycle lookup
    assign dout = mem[addr];

endmodule

`default_nettype wire

// ==== hdl/pcs_cache.sv ====
`default_nettype none

`include "cache_defs.svh"

module pcs_cache (
    input  logic                      clk,
    input  logic                      rst,

    // CPU side
    input  logic [31:0]               ufp_addr,
    input  logic                      ufp_rmask,
    input  logic [`CACHE_MASK_W-1:0]  ufp_wmask,
    input  logic [`CACHE_LINE_W-1:0]  ufp_wdata,
    output logic [`CACHE_WORD_W-1:0]  ufp_rdata,
    output logic                      ufp_resp,

    // Memory side
    output logic [31:0]               dfp_addr,
    output logic                      dfp_read,
    output logic                      dfp_write,
    input  logic [`CACHE_LINE_W-1:0]  dfp_rdata,
    output logic [`CACHE_LINE_W-1:0]  dfp_wdata,
    input  logic                      dfp_resp,

    // Committed store buffer line
    input  logic                      write_pcs_cacheline,
    input  logic [`CACHE_MASK_W-1:0]  pcs_cacheline_mask,
    input  logic [`CACHE_LINE_W-1:0]  pcs_cacheline
);

    cache_pkg::cpu_req_t                      req;
    cache_pkg::lookup_t                       lookup;
    cache_pkg::cache_state_t                  state;
    cache_pkg::mem_req_t                      ctrl_mem;
    cache_pkg::mem_req_t                      dfp_req;
    cache_pkg::tag_entry_t                    tag_din;
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]  way_tags;
    logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0] way_lines;
    logic [`CACHE_WAYS-1:0]                   way_valids;
    logic [`CACHE_WAYS-1:0]                   data_we;
    logic [`CACHE_WAYS-1:0]                   data_we_masked;
    logic [`CACHE_WAYS-1:0]                   tag_we;
    logic [`CACHE_WAYS-1:0]                   valid_we;
    logic                                     plru_we;
    logic [2:0]                               plru_bits;
    logic [2:0]                               plru_next;
    logic [`CACHE_LINE_W-1:0]                 merged_line;
    logic [`CACHE_MASK_W-1:0]                 merged_mask;

    assign req.addr     = ufp_addr;
    assign req.read     = ufp_rmask;
    assign req.wmask    = ufp_wmask;
    assign req.wdata    = ufp_wdata;
    assign req.pcs      = write_pcs_cacheline;
    assign req.pcs_mask = pcs_cacheline_mask;
    assign req.pcs_line = pcs_cacheline;

    // Stores mark the line dirty, a fill leaves it clean
    assign tag_din.dirty = (state != cache_pkg::allocate_s);
    assign tag_din.tag   = req.addr.f.tag;

    // No data write for an empty byte mask
    assign data_we_masked = data_we & {`CACHE_WAYS{|merged_mask}};

    // Victim line rides along with the writeback request
    always_comb begin
        dfp_req       = ctrl_mem;
        dfp_req.wdata = way_lines[lookup.victim_way];
    end

    assign dfp_addr  = dfp_req.addr;
    assign dfp_read  = dfp_req.read;
    assign dfp_write = dfp_req.write;
    assign dfp_wdata = dfp_req.wdata;

    cache_tag_match u_tag_match (
        .addr       (req.addr),
        .tags       (way_tags),
        .valids     (way_valids),
        .plru       (plru_bits),
        .lookup     (lookup)
    );

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .lookup     (lookup),
        .dfp_resp   (dfp_resp),
        .state      (state),
        .mem        (ctrl_mem),
        .data_we    (data_we),
        .tag_we     (tag_we),
        .valid_we   (valid_we),
        .plru_we    (plru_we),
        .ufp_resp   (ufp_resp)
    );

    cache_line_merge u_line_merge (
        .state      (state),
        .req        (req),
        .lookup     (lookup),
        .lines      (way_lines),
        .dfp_rdata  (dfp_rdata),
        .plru       (plru_bits),
        .wline      (merged_line),
        .wmask      (merged_mask),
        .rdata      (ufp_rdata),
        .plru_next  (plru_next)
    );

    cache_way_array #(.WIDTH(3)) u_plru_array (
        .clk        (clk),
        .rst        (rst),
        .we         (plru_we),
        .addr       (req.addr.f.index),
        .din        (plru_next),
        .dout       (plru_bits)
    );

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        cache_way_array #(.WIDTH(`CACHE_LINE_W)) u_data_array (
            .clk    (clk),
            .rst    (rst),
            .we     (data_we_masked[i]),
            .addr   (req.addr.f.index),
            .din    (merged_line),
            .dout   (way_lines[i])
        );

        cache_way_array #(.WIDTH(`CACHE_TAG_W + 1)) u_tag_array (
            .clk    (clk),
            .rst    (rst),
            .we     (tag_we[i]),
            .addr   (req.addr.f.index),
            .din    (tag_din),
            .dout   (way_tags[i])
        );

        cache_way_array #(.WIDTH(1)) u_valid_array (
            .clk    (clk),
            .rst    (rst),
            .we     (valid_we[i]),
            .addr   (req.addr.f.index),
            .din    (1'b1),
            .dout   (way_valids[i])
        );
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_way_array.sv
hdl/cache_tag_match.sv
hdl/cache_control.sv
hdl/cache_line_merge.sv
hdl/pcs_cache.sv
tb/tb_memory.sv
tb/tb_pcs_cache.sv

// ==== tb/tb_memory.sv ====
`default_nettype none

`include "cache_defs.svh"

module tb_memory (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              dfp_addr,
    input  logic                     dfp_read,
    input  logic                     dfp_write,
    input  logic [`CACHE_LINE_W-1:0] dfp_wdata,
    output logic [`CACHE_LINE_W-1:0] dfp_rdata,
    output logic                     dfp_resp,
    output int                       reads,
    output int                       writes
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINES = 256;

    // Byte address bits [12:5] pick the line
    logic [`CACHE_LINE_W-1:0] lines [LINES];
    logic                     busy;
    int                       delay;
    integer                   seed;

    // Each word starts as its byte address next to its complement
    initial begin
        logic [31:0] a;
        seed      = 31;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        busy      = 1'b0;
        delay     = 0;
        reads     = 0;
        writes    = 0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < 8; w++) begin
                a = 32'(l * 32 + w * 4);
                lines[l][w*32 +: 32] = {a[15:0], ~a[15:0]};
            end
        end
    end

    always @(posedge clk) begin
        dfp_resp <= 1'b0;
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (delay == 0) begin
                busy     <= 1'b0;
                dfp_resp <= 1'b1;
                if (dfp_read) begin
                    dfp_rdata <= lines[dfp_addr[12:5]];
                    reads     <= reads + 1;
                end else begin
                    lines[dfp_addr[12:5]] <= dfp_wdata;
                    writes                <= writes + 1;
                end
            end else begin
                delay <= delay - 1;
            end
        end else if ((dfp_read || dfp_write) && !dfp_resp) begin
            // New transaction, answer after a random wait
            busy  <= 1'b1;
            delay <= {$random(seed)} % 6;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_pcs_cache.sv ====
`default_nettype none

`include "cache_defs.svh"

module tb_pcs_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESP_LIMIT = 40;
    localparam int REQ_BUDGET = 250;
    localparam int CLK_PERIOD = 8;
    localparam int MEM_LINES  = 256;

    logic                     clk;
    logic                     rst;
    logic [31:0]              ufp_addr;
    logic                     ufp_rmask;
    logic [`CACHE_MASK_W-1:0] ufp_wmask;
    logic [`CACHE_LINE_W-1:0] ufp_wdata;
    logic [`CACHE_WORD_W-1:0] ufp_rdata;
    logic                     ufp_resp;
    logic [31:0]              dfp_addr;
    logic                     dfp_read;
    logic                     dfp_write;
    logic [`CACHE_LINE_W-1:0] dfp_rdata;
    logic [`CACHE_LINE_W-1:0] dfp_wdata;
    logic                     dfp_resp;
    logic                     write_pcs_cacheline;
    logic [`CACHE_MASK_W-1:0] pcs_cacheline_mask;
    logic [`CACHE_LINE_W-1:0] pcs_cacheline;
    int                       mem_reads;
    int                       mem_writes;
    integer                   seed;

    // Expected contents of every line, as the CPU should see it
    logic [`CACHE_LINE_W-1:0] golden [MEM_LINES];

    pcs_cache u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .ufp_addr            (ufp_addr),
        .ufp_rmask           (ufp_rmask),
        .ufp_wmask           (ufp_wmask),
        .ufp_wdata           (ufp_wdata),
        .ufp_rdata           (ufp_rdata),
        .ufp_resp            (ufp_resp),
        .dfp_addr            (dfp_addr),
        .dfp_read            (dfp_read),
        .dfp_write           (dfp_write),
        .dfp_rdata           (dfp_rdata),
        .dfp_wdata           (dfp_wdata),
        .dfp_resp            (dfp_resp),
        .write_pcs_cacheline (write_pcs_cacheline),
        .pcs_cacheline_mask  (pcs_cacheline_mask),
        .pcs_cacheline       (pcs_cacheline)
    );

    tb_memory u_mem (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .reads     (mem_reads),
        .writes    (mem_writes)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    // Whole regression must fit in the request budget
    initial begin
        #(REQ_BUDGET * RESP_LIMIT * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        abort_run();
    end

    function automatic logic [31:0] make_addr(input int tag, input int index, input int offset);
        return 32'(tag * 512 + index * 32 + offset);
    endfunction

    function automatic int slot_of(input logic [31:0] addr);
        return int'(addr[12:5]);
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] merge_bytes(
        input logic [`CACHE_LINE_W-1:0] old_line,
        input logic [`CACHE_MASK_W-1:0] mask,
        input logic [`CACHE_LINE_W-1:0] data
    );
        logic [`CACHE_LINE_W-1:0] res;
        res = old_line;
        for (int b = 0; b < `CACHE_MASK_W; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] random_line();
        logic [`CACHE_LINE_W-1:0] res;
        for (int i = 0; i < 8; i++) begin
            res[i*32 +: 32] = $random(seed);
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [`CACHE_WORD_W-1:0] got,
                              input logic [`CACHE_WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input logic [`CACHE_LINE_W-1:0] got,
                              input logic [`CACHE_LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Drive one request and hold it until ufp_resp
    task automatic issue(input cache_pkg::cpu_req_t r, output logic [`CACHE_WORD_W-1:0] rdata,
                         output int cycles);
        int n;
        @(posedge clk);
        ufp_addr            <= r.addr;
        ufp_rmask           <= r.read;
        ufp_wmask           <= r.wmask;
        ufp_wdata           <= r.wdata;
        write_pcs_cacheline <= r.pcs;
        pcs_cacheline_mask  <= r.pcs_mask;
        pcs_cacheline       <= r.pcs_line;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > RESP_LIMIT) begin
                $display("No ufp_resp within %0d cycles for address %h", RESP_LIMIT, r.addr);
                abort_run();
            end
        end while (!ufp_resp);
        rdata  = ufp_rdata;
        cycles = n;
        @(posedge clk);
        ufp_rmask           <= 1'b0;
        ufp_wmask           <= '0;
        write_pcs_cacheline <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output int cycles);
        cache_pkg::cpu_req_t      r;
        logic [`CACHE_WORD_W-1:0] rdata;
        r      = '0;
        r.addr = addr;
        r.read = 1'b1;
        issue(r, rdata, cycles);
        check_word($sformatf("ufp_rdata@%h", addr), rdata,
                   golden[slot_of(addr)][addr[4:2]*32 +: 32]);
    endtask

    task automatic write_bytes(input logic [31:0] addr, input logic [`CACHE_MASK_W-1:0] mask,
                               input logic [`CACHE_LINE_W-1:0] data);
        cache_pkg::cpu_req_t      r;
        logic [`CACHE_WORD_W-1:0] rdata;
        int                       cycles;
        r       = '0;
        r.addr  = addr;
        r.wmask = mask;
        r.wdata = data;
        issue(r, rdata, cycles);
        golden[slot_of(addr)] = merge_bytes(golden[slot_of(addr)], mask, data);
    endtask

    task automatic pcs_merge(input logic [31:0] addr, input logic [`CACHE_MASK_W-1:0] mask,
                             input logic [`CACHE_LINE_W-1:0] data, output int cycles);
        cache_pkg::cpu_req_t      r;
        logic [`CACHE_WORD_W-1:0] rdata;
        r          = '0;
        r.addr     = addr;
        r.pcs      = 1'b1;
        r.pcs_mask = mask;
        r.pcs_line = data;
        issue(r, rdata, cycles);
        golden[slot_of(addr)] = merge_bytes(golden[slot_of(addr)], mask, data);
    endtask

    task automatic test_read_miss();
        int reads_before;
        int writes_before;
        int cycles;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        for (int w = 0; w < 8; w++) begin
            read_word(make_addr(1, 2, w * 4), cycles);
        end
        check_count("dfp_read count", mem_reads - reads_before, 1);
        check_count("dfp_write count", mem_writes - writes_before, 0);
    endtask

    task automatic test_hit_latency();
        int reads_before;
        int writes_before;
        int cycles;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        read_word(make_addr(1, 2, 12), cycles);
        check_count("ufp_resp latency", cycles, 2);
        check_count("dfp_read count", mem_reads - reads_before, 0);
        check_count("dfp_write count", mem_writes - writes_before, 0);
    endtask

    task automatic test_byte_write();
        int cycles;
        write_bytes(make_addr(2, 5, 0), 32'h0f0f_00f3, random_line());
        for (int w = 0; w < 8; w++) begin
            read_word(make_addr(2, 5, w * 4), cycles);
        end
    endtask

    task automatic test_pcs_merge();
        int cycles;
        // Resident line from the first test
        pcs_merge(make_addr(1, 2, 0), 32'hff00_0ff0, random_line(), cycles);
        check_count("pcs ufp_resp latency", cycles, 3);
        // Missing line is filled first, then merged
        pcs_merge(make_addr(3, 6, 0), 32'h00ff_c003, random_line(), cycles);
        for (int w = 0; w < 8; w++) begin
            read_word(make_addr(1, 2, w * 4), cycles);
            read_word(make_addr(3, 6, w * 4), cycles);
        end
    endtask

    task automatic test_eviction();
        int          writes_before;
        int          cycles;
        logic [31:0] first;
        writes_before = 0;
        for (int t = 4; t < 9; t++) begin
            if (t == 8) begin
                writes_before = mem_writes;
            end
            write_bytes(make_addr(t, 9, 0), 32'hffff_0f0f ^ 32'(t), random_line());
        end
        check_count("dfp_write count", mem_writes - writes_before, 1);
        // Ways 0 to 3 touched in order leave the tree pointing at way 0
        first = make_addr(4, 9, 0);
        check_line("u_mem.lines", u_mem.lines[slot_of(first)], golden[slot_of(first)]);
        for (int t = 4; t < 9; t++) begin
            read_word(make_addr(t, 9, 0), cycles);
            read_word(make_addr(t, 9, 20), cycles);
        end
    endtask

    task automatic test_random_mix();
        int                       idx [3];
        int                       kind;
        int                       tag;
        int                       set_sel;
        int                       word;
        int                       cycles;
        logic [31:0]              addr;
        logic [`CACHE_MASK_W-1:0] mask;
        idx[0] = 1;
        idx[1] = 10;
        idx[2] = 13;
        for (int n = 0; n < 200; n++) begin
            kind    = {$random(seed)} % 3;
            tag     = {$random(seed)} % 6;
            set_sel = {$random(seed)} % 3;
            word    = {$random(seed)} % 8;
            mask    = $random(seed);
            addr    = make_addr(tag, idx[set_sel], word * 4);
            case (kind)
                0: read_word(addr, cycles);
                1: begin
                    // An empty mask would not be a write request
                    if (mask == '0) begin
                        mask = 32'h1;
                    end
                    write_bytes(addr, mask, random_line());
                end
                default: pcs_merge(addr, mask, random_line(), cycles);
            endcase
        end
    endtask

    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        ufp_addr            = '0;
        ufp_rmask           = 1'b0;
        ufp_wmask           = '0;
        ufp_wdata           = '0;
        write_pcs_cacheline = 1'b0;
        pcs_cacheline_mask  = '0;
        pcs_cacheline       = '0;
        seed                = 31;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < MEM_LINES; i++) begin
            golden[i] = u_mem.lines[i];
        end
        test_read_miss();
        test_hit_latency();
        test_byte_write();
        test_pcs_merge();
        test_eviction();
        test_random_mix();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
